// File: files.f
+incdir+verilog
verilog/groovy_pkg.sv
verilog/modeline_regs.sv
verilog/raster_timing.sv
verilog/chunk_unpacker.sv
verilog/video_output_stage.sv
verilog/groovy_video_top.sv
testbench/tb_groovy_video.sv

// File: testbench/tb_groovy_video.sv
// testbench for the groovy video core
// random modelines and chunks, checked cycle by cycle against a raster model
`timescale 1ns/1ns
`include "groovy_macros.svh"

module tb_groovy_video;
	import groovy_pkg::*;

	localparam int NUM_MODES   = 4;
	localparam int MODE_FRAMES = 2;     // frames shown per random modeline
	localparam int MAX_FRAME   = 36 * 36; // largest random frame in pixels
	localparam int MAX_DIV     = 5;
	localparam int DEF_FRAME   = (`GV_DEF_H + `GV_DEF_HFP + `GV_DEF_HS + `GV_DEF_HBP) *
		(`GV_DEF_V + `GV_DEF_VFP + `GV_DEF_VS + `GV_DEF_VBP) * `GV_DEF_CE_DIV;
	localparam int WATCHDOG_NS =
		(NUM_MODES * (MODE_FRAMES + 4) * MAX_FRAME * MAX_DIV + 2 * DEF_FRAME + 5000) * 10;

	// modeline fields in the model arrays
	localparam int M_H = 0, M_HFP = 1, M_HS = 2, M_HBP = 3;
	localparam int M_V = 4, M_VFP = 5, M_VS = 6, M_VBP = 7, M_DIV = 8;

	logic clk_sys, arst_n;
	logic mode_load, chunk_load;
	coord_t h_active, v_active;
	porch_t h_fp, h_sync, h_bp, v_fp, v_sync, v_bp;
	logic [7:0] ce_div;
	chunk_t chunk_data;
	logic ce_pix, hsync, vsync, de, vblank, mode_changed, underrun, chunk_empty;
	rgb_t video_rgb;
	coord_t vcount;

	int seed = 32'h4e10e68a;
	int errors, frames, swaps, mc_pulses, model_underruns, dut_underruns, pixels_shown;
	logic withhold; // host stops refilling

	int act_m[9], pend_m[9];
	logic pend_valid;
	int m_h, m_v; // raster position counted at the next ce_pix
	logic r_de, r_hs, r_vs, r_vb;
	int r_vcount;
	logic o_de, o_hs, o_vs, o_vb, o_ur, o_mc;
	logic [23:0] o_rgb;
	logic [23:0] pix_q[$]; // pixels the host has handed over
	int ce_gap;
	logic ce_seen;

	groovy_video_top DUT (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.mode_load    (mode_load),
		.h_active     (h_active),
		.h_fp         (h_fp),
		.h_sync       (h_sync),
		.h_bp         (h_bp),
		.v_active     (v_active),
		.v_fp         (v_fp),
		.v_sync       (v_sync),
		.v_bp         (v_bp),
		.ce_div       (ce_div),
		.chunk_load   (chunk_load),
		.chunk_data   (chunk_data),
		.ce_pix       (ce_pix),
		.video_rgb    (video_rgb),
		.hsync        (hsync),
		.vsync        (vsync),
		.de           (de),
		.vblank       (vblank),
		.vcount       (vcount),
		.mode_changed (mode_changed),
		.underrun     (underrun),
		.chunk_empty  (chunk_empty)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %0t ns %s: expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	function automatic logic in_window(input int pos, input int start, input int len);
		return (pos >= start) && (pos < start + len);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// reference model, sampled on the falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic reset_model();
		act_m = '{`GV_DEF_H, `GV_DEF_HFP, `GV_DEF_HS, `GV_DEF_HBP,
			`GV_DEF_V, `GV_DEF_VFP, `GV_DEF_VS, `GV_DEF_VBP, `GV_DEF_CE_DIV};
		pend_valid = 1'b0;
		{m_h, m_v, r_vcount, ce_gap} = '0;
		{r_de, r_hs, r_vs, r_vb, ce_seen} = '0;
		{o_de, o_hs, o_vs, o_vb, o_ur, o_mc, o_rgb} = '0;
		pix_q.delete();
	endtask

	task automatic compare_outputs();
		check_value("video_rgb", video_rgb, o_rgb);
		check_value("de", de, o_de);
		check_value("hsync", hsync, o_hs);
		check_value("vsync", vsync, o_vs);
		check_value("vblank", vblank, o_vb);
		check_value("vcount", vcount, r_vcount);
		check_value("underrun", underrun, o_ur);
		check_value("mode_changed", mode_changed, o_mc);
		check_value("chunk_empty", chunk_empty, pix_q.size() == 0);
		if (mode_changed)
			mc_pulses++;
		if (underrun)
			dut_underruns++;
		ce_gap++;
		if (ce_pix) begin
			if (ce_seen)
				check_value("ce_pix gap", ce_gap, act_m[M_DIV]);
			ce_gap  = 0;
			ce_seen = 1'b1;
		end
	endtask

	task automatic step_model();
		int h_tot;
		int v_tot;
		logic frame_done;
		h_tot = act_m[M_H] + act_m[M_HFP] + act_m[M_HS] + act_m[M_HBP];
		v_tot = act_m[M_V] + act_m[M_VFP] + act_m[M_VS] + act_m[M_VBP];
		frame_done = 1'b0;
		o_ur = 1'b0;
		o_mc = 1'b0;
		if (ce_pix) begin
			// output stage takes the previous pixel's raster state
			{o_de, o_hs, o_vs, o_vb} = {r_de, r_hs, r_vs, r_vb};
			if (!r_de) begin
				o_rgb = '0;
			end else if (pix_q.size() != 0) begin
				o_rgb = pix_q.pop_front();
				pixels_shown++;
			end else begin
				o_rgb = `GV_FILL_RGB; // no data in the active area
				o_ur  = 1'b1;
				model_underruns++;
			end
			r_de     = (m_h < act_m[M_H]) && (m_v < act_m[M_V]);
			r_hs     = in_window(m_h, act_m[M_H] + act_m[M_HFP], act_m[M_HS]);
			r_vs     = in_window(m_v, act_m[M_V] + act_m[M_VFP], act_m[M_VS]);
			r_vb     = (m_v >= act_m[M_V]);
			r_vcount = m_v;
			if (m_h == h_tot - 1) begin
				m_h = 0;
				frame_done = (m_v == v_tot - 1);
				m_v = frame_done ? 0 : m_v + 1;
			end else begin
				m_h++;
			end
			if (frame_done) begin
				frames++;
				if (pend_valid) begin
					act_m = pend_m; // new mode from the very next pixel
					pend_valid = 1'b0;
					o_mc = 1'b1;
					swaps++;
				end
			end
		end
		if (mode_load) begin
			pend_m = '{h_active, h_fp, h_sync, h_bp, v_active, v_fp, v_sync, v_bp, ce_div};
			pend_valid = 1'b1;
		end
		if (chunk_load) begin
			for (int i = 0; i < `GV_CHUNK_PIXELS; i++)
				pix_q.push_back(chunk_data[i*`GV_PIXEL_BITS +: `GV_PIXEL_BITS]);
		end
	endtask

	always @(negedge clk_sys) begin
		if (!arst_n) begin
			reset_model();
		end else begin
			compare_outputs();
			step_model();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// host side
	////////////////////////////////////////////////////////////////////////////

	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic load_random_mode();
		h_active  = coord_t'(rand_range(4, 24));
		h_fp      = porch_t'(rand_range(1, 4));
		h_sync    = porch_t'(rand_range(1, 4));
		h_bp      = porch_t'(rand_range(1, 4));
		v_active  = coord_t'(rand_range(4, 24));
		v_fp      = porch_t'(rand_range(1, 4));
		v_sync    = porch_t'(rand_range(1, 4));
		v_bp      = porch_t'(rand_range(1, 4));
		ce_div    = 8'(rand_range(2, MAX_DIV));
		mode_load = 1'b1;
		step();
		mode_load = 1'b0;
	endtask

	task automatic wait_mode_change();
		do step(); while (!mode_changed);
	endtask

	task automatic wait_frames(input int n);
		int target;
		target = frames + n;
		while (frames < target)
			step();
	endtask

	// refill whenever the unpacker runs dry, after a random gap
	initial begin
		@(posedge arst_n);
		forever begin
			step();
			if (chunk_empty && !withhold) begin
				repeat (rand_range(0, 63)) step();
				if (!withhold) begin
					for (int i = 0; i < `GV_PIXEL_BITS * `GV_CHUNK_PIXELS / 32; i++)
						chunk_data[i*32 +: 32] = $random(seed);
					chunk_load = 1'b1;
					step();
					chunk_load = 1'b0;
				end
			end
		end
	end

	initial begin
		int m;
		arst_n     = 1'b0;
		mode_load  = 1'b0;
		chunk_load = 1'b0;
		{h_active, h_fp, h_sync, h_bp} = '0;
		{v_active, v_fp, v_sync, v_bp} = '0;
		ce_div     = '0;
		chunk_data = '0;
		withhold   = 1'b0;
		{errors, frames, swaps, mc_pulses} = '0;
		{model_underruns, dut_underruns, pixels_shown} = '0;
		repeat (10) @(posedge clk_sys);
		#1;
		arst_n = 1'b1;

		for (m = 0; m < NUM_MODES; m++) begin
			repeat (rand_range(1, 60)) step(); // load lands mid-frame
			load_random_mode();
			if (m == 1) begin
				repeat (rand_range(1, 8)) step();
				load_random_mode(); // overwrites the pending mode
			end
			wait_mode_change();
			if (m == 2) begin
				withhold = 1'b1;
				step();
				step();
				while (!chunk_empty)
					step();
				wait_frames(2); // whole frames of fill colour
				withhold = 1'b0;
			end else begin
				wait_frames(MODE_FRAMES);
			end
		end
		wait_frames(1);

		check_value("mode_changed pulses", mc_pulses, swaps);
		check_value("underrun pulses", dut_underruns, model_underruns);
		check_value("underrun exercised", dut_underruns != 0, 1);
		$display("errors %0d, frames %0d, pixels %0d, underruns %0d, mode changes %0d",
			errors, frames, pixels_shown, model_underruns, swaps);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns before the run finished, %0d errors so far",
			WATCHDOG_NS, errors);
		$display("tests failed");
		$finish;
	end

endmodule

// File: verilog/groovy_video_top.sv
// groovy video core top level
// modeline registers, raster timing, chunk unpacker and output stage
`timescale 1ns/1ns

module groovy_video_top (
	input  logic              clk_sys,
	input  logic              arst_n,
	input  logic              mode_load,
	input  groovy_pkg::coord_t h_active,
	input  groovy_pkg::porch_t h_fp,
	input  groovy_pkg::porch_t h_sync,
	input  groovy_pkg::porch_t h_bp,
	input  groovy_pkg::coord_t v_active,
	input  groovy_pkg::porch_t v_fp,
	input  groovy_pkg::porch_t v_sync,
	input  groovy_pkg::porch_t v_bp,
	input  logic [7:0]        ce_div,
	input  logic              chunk_load,
	input  groovy_pkg::chunk_t chunk_data,
	output logic              ce_pix,
	output groovy_pkg::rgb_t  video_rgb,
	output logic              hsync,
	output logic              vsync,
	output logic              de,
	output logic              vblank,
	output groovy_pkg::coord_t vcount,
	output logic              mode_changed,
	output logic              underrun,
	output logic              chunk_empty
);
	import groovy_pkg::*;

	coord_t act_h_active, act_v_active;
	porch_t act_h_fp, act_h_sync, act_h_bp;
	porch_t act_v_fp, act_v_sync, act_v_bp;
	logic [7:0] act_ce_div;
	logic frame_end;
	logic raster_de, raster_hsync, raster_vsync, raster_vblank;
	logic pixel_valid;
	rgb_t pixel_rgb;

	modeline_regs u_modeline_regs (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.mode_load    (mode_load),
		.frame_end    (frame_end),
		.h_active     (h_active),
		.h_fp         (h_fp),
		.h_sync       (h_sync),
		.h_bp         (h_bp),
		.v_active     (v_active),
		.v_fp         (v_fp),
		.v_sync       (v_sync),
		.v_bp         (v_bp),
		.ce_div       (ce_div),
		.act_h_active (act_h_active),
		.act_h_fp     (act_h_fp),
		.act_h_sync   (act_h_sync),
		.act_h_bp     (act_h_bp),
		.act_v_active (act_v_active),
		.act_v_fp     (act_v_fp),
		.act_v_sync   (act_v_sync),
		.act_v_bp     (act_v_bp),
		.act_ce_div   (act_ce_div),
		.mode_changed (mode_changed)
	);

	// timing and pixel paths run side by side
	raster_timing u_raster_timing (
		.clk_sys       (clk_sys),
		.arst_n        (arst_n),
		.act_h_active  (act_h_active),
		.act_h_fp      (act_h_fp),
		.act_h_sync    (act_h_sync),
		.act_h_bp      (act_h_bp),
		.act_v_active  (act_v_active),
		.act_v_fp      (act_v_fp),
		.act_v_sync    (act_v_sync),
		.act_v_bp      (act_v_bp),
		.act_ce_div    (act_ce_div),
		.ce_pix        (ce_pix),
		.frame_end     (frame_end),
		.raster_de     (raster_de),
		.raster_hsync  (raster_hsync),
		.raster_vsync  (raster_vsync),
		.raster_vblank (raster_vblank),
		.vcount        (vcount)
	);

	chunk_unpacker u_chunk_unpacker (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.chunk_load  (chunk_load),
		.ce_pix      (ce_pix),
		.raster_de   (raster_de),
		.chunk_data  (chunk_data),
		.chunk_empty (chunk_empty),
		.pixel_valid (pixel_valid),
		.pixel_rgb   (pixel_rgb)
	);

	video_output_stage u_video_output_stage (
		.clk_sys       (clk_sys),
		.arst_n        (arst_n),
		.ce_pix        (ce_pix),
		.raster_de     (raster_de),
		.raster_hsync  (raster_hsync),
		.raster_vsync  (raster_vsync),
		.raster_vblank (raster_vblank),
		.pixel_valid   (pixel_valid),
		.pixel_rgb     (pixel_rgb),
		.video_rgb     (video_rgb),
		.hsync         (hsync),
		.vsync         (vsync),
		.de            (de),
		.vblank        (vblank),
		.underrun      (underrun)
	);

endmodule

// File: verilog/video_output_stage.sv
// video output stage
// merges raster state and pixel data into registered video outputs
`timescale 1ns/1ns
`include "groovy_macros.svh"

module video_output_stage (
	input  logic             clk_sys,
	input  logic             arst_n,
	input  logic             ce_pix,
	input  logic             raster_de,
	input  logic             raster_hsync,
	input  logic             raster_vsync,
	input  logic             raster_vblank,
	input  logic             pixel_valid,
	input  groovy_pkg::rgb_t pixel_rgb,
	output groovy_pkg::rgb_t video_rgb,
	output logic             hsync,
	output logic             vsync,
	output logic             de,
	output logic             vblank,
	output logic             underrun
);
	import groovy_pkg::*;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			video_rgb <= '0;
			hsync     <= 1'b0;
			vsync     <= 1'b0;
			de        <= 1'b0;
			vblank    <= 1'b0;
			underrun  <= 1'b0;
		end else begin
			underrun <= 1'b0; // single clock pulse
			if (ce_pix) begin
				hsync  <= raster_hsync;
				vsync  <= raster_vsync;
				de     <= raster_de;
				vblank <= raster_vblank;
				if (!raster_de) begin
					video_rgb <= '0; // black outside the active area
				end else if (pixel_valid) begin
					video_rgb <= pixel_rgb;
				end else begin
					video_rgb <= rgb_t'(`GV_FILL_RGB);
					underrun  <= 1'b1;
				end
			end
		end
	end

endmodule

// File: verilog/chunk_unpacker.sv
// chunk unpacker
// holds one 40 pixel chunk and hands out its pixels lowest first
`timescale 1ns/1ns
`include "groovy_macros.svh"

module chunk_unpacker (
	input  logic              clk_sys,
	input  logic              arst_n,
	input  logic              chunk_load,
	input  logic              ce_pix,
	input  logic              raster_de,
	input  groovy_pkg::chunk_t chunk_data,
	output logic              chunk_empty,
	output logic              pixel_valid,
	output groovy_pkg::rgb_t  pixel_rgb
);
	import groovy_pkg::*;

	localparam int IDX_W = $clog2(`GV_CHUNK_PIXELS);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`GV_CHUNK_PIXELS - 1);

	chunk_t chunk_q;
	logic [IDX_W-1:0] idx; // next pixel to show
	logic full;
	logic take;

	assign take        = ce_pix & raster_de & full; // one displayed pixel
	assign chunk_empty = ~full;
	assign pixel_valid = full;
	assign pixel_rgb   = rgb_t'(chunk_q[idx*`GV_PIXEL_BITS +: `GV_PIXEL_BITS]);

	// loads while full are dropped
	always_ff @(posedge clk_sys) begin
		if (chunk_load && !full)
			chunk_q <= chunk_data;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			full <= 1'b0;
			idx  <= '0;
		end else if (chunk_load && !full) begin
			full <= 1'b1;
			idx  <= '0;
		end else if (take) begin
			if (idx == LAST_IDX) begin
				full <= 1'b0; // chunk_empty rises next cycle
				idx  <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	// host may only refill an empty unpacker
	a_load_when_empty: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		chunk_load |-> chunk_empty
	);

endmodule

// File: verilog/raster_timing.sv
// raster timing
// pixel clock enable divider and h/v counters with sync, blanking and de
`timescale 1ns/1ns

module raster_timing (
	input  logic              clk_sys,
	input  logic              arst_n,
	input  groovy_pkg::coord_t act_h_active,
	input  groovy_pkg::porch_t act_h_fp,
	input  groovy_pkg::porch_t act_h_sync,
	input  groovy_pkg::porch_t act_h_bp,
	input  groovy_pkg::coord_t act_v_active,
	input  groovy_pkg::porch_t act_v_fp,
	input  groovy_pkg::porch_t act_v_sync,
	input  groovy_pkg::porch_t act_v_bp,
	input  logic [7:0]        act_ce_div,
	output logic              ce_pix,
	output logic              frame_end,
	output logic              raster_de,
	output logic              raster_hsync,
	output logic              raster_vsync,
	output logic              raster_vblank,
	output groovy_pkg::coord_t vcount
);
	import groovy_pkg::*;

	logic [7:0] ce_cnt;
	coord_t h_cnt, v_cnt;
	coord_t hs_start, hs_end, h_total;
	coord_t vs_start, vs_end, v_total;
	logic h_last, v_last;

	// sync window and totals from the active modeline
	assign hs_start = act_h_active + coord_t'(act_h_fp);
	assign hs_end   = hs_start + coord_t'(act_h_sync);
	assign h_total  = hs_end + coord_t'(act_h_bp);
	assign vs_start = act_v_active + coord_t'(act_v_fp);
	assign vs_end   = vs_start + coord_t'(act_v_sync);
	assign v_total  = vs_end + coord_t'(act_v_bp);

	assign h_last    = (h_cnt == h_total - 16'd1);
	assign v_last    = (v_cnt == v_total - 16'd1);
	assign frame_end = ce_pix & h_last & v_last;

	////////////////////////////////////////////////////////////////////////////
	// pixel clock enable
	////////////////////////////////////////////////////////////////////////////

	// >= so a smaller divisor after a swap still wraps
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ce_cnt <= '0;
			ce_pix <= 1'b0;
		end else if (ce_cnt >= act_ce_div - 8'd1) begin
			ce_cnt <= '0;
			ce_pix <= 1'b1;
		end else begin
			ce_cnt <= ce_cnt + 8'd1;
			ce_pix <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// raster counters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			h_cnt         <= '0;
			v_cnt         <= '0;
			raster_de     <= 1'b0;
			raster_hsync  <= 1'b0;
			raster_vsync  <= 1'b0;
			raster_vblank <= 1'b0;
			vcount        <= '0;
		end else if (ce_pix) begin
			// state of the pixel being counted now
			raster_de     <= (h_cnt < act_h_active) && (v_cnt < act_v_active);
			raster_hsync  <= (h_cnt >= hs_start) && (h_cnt < hs_end);
			raster_vsync  <= (v_cnt >= vs_start) && (v_cnt < vs_end);
			raster_vblank <= (v_cnt >= act_v_active);
			vcount        <= v_cnt;
			if (h_last) begin
				h_cnt <= '0;
				v_cnt <= v_last ? '0 : v_cnt + 16'd1; // next line or new frame
			end else begin
				h_cnt <= h_cnt + 16'd1;
			end
		end
	end

	// divisor is at least 2
	a_ce_pix_isolated: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		ce_pix |=> !ce_pix
	);

endmodule

// File: verilog/modeline_regs.sv
// modeline registers
// pending and active modeline, swapped only at the end of a frame
`timescale 1ns/1ns
`include "groovy_macros.svh"

module modeline_regs (
	input  logic              clk_sys,
	input  logic              arst_n,
	input  logic              mode_load,
	input  logic              frame_end,
	input  groovy_pkg::coord_t h_active,
	input  groovy_pkg::porch_t h_fp,
	input  groovy_pkg::porch_t h_sync,
	input  groovy_pkg::porch_t h_bp,
	input  groovy_pkg::coord_t v_active,
	input  groovy_pkg::porch_t v_fp,
	input  groovy_pkg::porch_t v_sync,
	input  groovy_pkg::porch_t v_bp,
	input  logic [7:0]        ce_div,
	output groovy_pkg::coord_t act_h_active,
	output groovy_pkg::porch_t act_h_fp,
	output groovy_pkg::porch_t act_h_sync,
	output groovy_pkg::porch_t act_h_bp,
	output groovy_pkg::coord_t act_v_active,
	output groovy_pkg::porch_t act_v_fp,
	output groovy_pkg::porch_t act_v_sync,
	output groovy_pkg::porch_t act_v_bp,
	output logic [7:0]        act_ce_div,
	output logic              mode_changed
);
	import groovy_pkg::*;

	coord_t pend_h_active, pend_v_active;
	porch_t pend_h_fp, pend_h_sync, pend_h_bp;
	porch_t pend_v_fp, pend_v_sync, pend_v_bp;
	logic [7:0] pend_ce_div;
	logic pend_valid;
	logic swap;

	assign swap = frame_end & pend_valid; // frame boundary with a mode waiting

	// host copy, a later load simply overwrites it
	always_ff @(posedge clk_sys) begin
		if (mode_load) begin
			pend_h_active <= h_active;
			pend_h_fp     <= h_fp;
			pend_h_sync   <= h_sync;
			pend_h_bp     <= h_bp;
			pend_v_active <= v_active;
			pend_v_fp     <= v_fp;
			pend_v_sync   <= v_sync;
			pend_v_bp     <= v_bp;
			pend_ce_div   <= ce_div;
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			pend_valid   <= 1'b0;
			mode_changed <= 1'b0;
			act_h_active <= `GV_DEF_H;
			act_h_fp     <= `GV_DEF_HFP;
			act_h_sync   <= `GV_DEF_HS;
			act_h_bp     <= `GV_DEF_HBP;
			act_v_active <= `GV_DEF_V;
			act_v_fp     <= `GV_DEF_VFP;
			act_v_sync   <= `GV_DEF_VS;
			act_v_bp     <= `GV_DEF_VBP;
			act_ce_div   <= `GV_DEF_CE_DIV;
		end else begin
			mode_changed <= swap; // one pulse per swap
			if (swap) begin
				act_h_active <= pend_h_active;
				act_h_fp     <= pend_h_fp;
				act_h_sync   <= pend_h_sync;
				act_h_bp     <= pend_h_bp;
				act_v_active <= pend_v_active;
				act_v_fp     <= pend_v_fp;
				act_v_sync   <= pend_v_sync;
				act_v_bp     <= pend_v_bp;
				act_ce_div   <= pend_ce_div;
				pend_valid   <= 1'b0;
			end
			if (mode_load)
				pend_valid <= 1'b1; // a load on the swap cycle stays pending
		end
	end

	// host keeps every field nonzero and the divisor at 2 or more
	a_mode_load_legal: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		mode_load |-> (ce_div >= 8'd2) && (h_active != '0) && (v_active != '0) &&
			(h_fp != '0) && (h_sync != '0) && (h_bp != '0) &&
			(v_fp != '0) && (v_sync != '0) && (v_bp != '0)
	);

endmodule

// File: verilog/groovy_pkg.sv
// groovy video shared types
// pixel, chunk and raster counter types used across the core
`include "groovy_macros.svh"

package groovy_pkg;

	// one pixel, red in the top byte
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// 40 pixels per chunk, pixel 0 in the lowest bits
	typedef logic [`GV_PIXEL_BITS*`GV_CHUNK_PIXELS-1:0] chunk_t;

	// active sizes and raster counts
	typedef logic [15:0] coord_t;

	typedef logic [7:0] porch_t; // porch or sync length

endpackage

// File: verilog/groovy_macros.svh
// groovy video constants
// chunk geometry, no-data colour and the modeline loaded at reset
`ifndef GROOVY_MACROS_SVH
`define GROOVY_MACROS_SVH

// chunk geometry
`define GV_PIXEL_BITS   24
`define GV_CHUNK_PIXELS 40

// dark yellow, shown while the active area has no data
`define GV_FILL_RGB     24'hd19628

////////////////////////////////////////////////////////////////////////////
// default modeline, 256x240 at ce_div 16
////////////////////////////////////////////////////////////////////////////

`define GV_DEF_H        16'd256
`define GV_DEF_HFP      8'd10
`define GV_DEF_HS       8'd24
`define GV_DEF_HBP      8'd41

`define GV_DEF_V        16'd240
`define GV_DEF_VFP      8'd2
`define GV_DEF_VS       8'd3
`define GV_DEF_VBP      8'd16

`define GV_DEF_CE_DIV   8'd16 // clk_sys cycles per pixel

`endif
